// ==== vlog.f ====
design/csr_pkg.sv
design/csr_write_if.sv
design/csr_trap_regs.sv
design/csr_counters.sv
design/csr_trap_ctrl.sv
design/csr_read_mux.sv
design/csr_unit.sv
tests/csr_unit_chk.sv
tests/csr_unit_tb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

sources:
  - files:
      - design/csr_pkg.sv
      - design/csr_write_if.sv
      - design/csr_trap_regs.sv
      - design/csr_counters.sv
      - design/csr_trap_ctrl.sv
      - design/csr_read_mux.sv
      - design/csr_unit.sv
  - target: test
    files:
      - tests/csr_unit_chk.sv
      - tests/csr_unit_tb.sv

// ==== tests/csr_unit_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_unit_tb;

	localparam int NUM_IRQ        = 16;
	localparam int TIMEOUT_CYCLES = 2000; // Tests need about 300 cycles
	localparam int IDLE_CYCLES    = 20;

	logic                clk;
	logic                rst_n;
	logic [11:0]         addr;
	csr_pkg::csr_data_t  wdata;
	logic                wen;
	csr_pkg::csr_wtype_e wtype;
	logic                ren;
	csr_pkg::csr_data_t  rdata;
	logic                illegal;
	csr_pkg::csr_data_t  trap_addr;
	logic                trap_is_irq;
	logic                trap_enter_vld;
	logic                trap_enter_rdy;
	csr_pkg::csr_data_t  mepc_in;
	csr_pkg::except_e    except;
	logic                delay_irq_entry;
	logic [NUM_IRQ-1:0]  irq;
	logic                irq_software;
	logic                irq_timer;
	logic                instr_ret;

	int          data_errors;
	int          bit_errors;
	int          cycle_count;
	string       test_name;
	logic [15:0] lfsr_state;

	csr_unit #(.NUM_IRQ(NUM_IRQ), .MTVEC_INIT(32'h0)) u_csr_unit (
		.clk(clk), .rst_n(rst_n), .addr(addr), .wdata(wdata), .wen(wen), .wtype(wtype),
		.ren(ren), .rdata(rdata), .illegal(illegal), .trap_addr(trap_addr),
		.trap_is_irq(trap_is_irq), .trap_enter_vld(trap_enter_vld),
		.trap_enter_rdy(trap_enter_rdy), .mepc_in(mepc_in), .except(except),
		.delay_irq_entry(delay_irq_entry), .irq(irq), .irq_software(irq_software),
		.irq_timer(irq_timer), .instr_ret(instr_ret)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	// Run limit
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// --------------------
	// Reference rules and random data

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic csr_pkg::csr_data_t lfsr_word();
		csr_pkg::csr_data_t w;
		for (int i = 0; i < 32; i++) begin
			w[i] = lfsr_bit(); // One step per bit
		end
		return w;
	endfunction

	function automatic csr_pkg::csr_data_t apply_wtype(input csr_pkg::csr_data_t prev,
		input csr_pkg::csr_data_t wd, input csr_pkg::csr_wtype_e wt);
		if (wt == csr_pkg::CSR_WTYPE_S)
			return prev | wd;
		else if (wt == csr_pkg::CSR_WTYPE_C)
			return prev & ~wd;
		return wd;
	endfunction

	function automatic csr_pkg::csr_data_t mstatus_word(input logic mie_b, input logic mpie_b);
		csr_pkg::csr_data_t w;
		w    = 32'h0000_1800; // MPP reads as machine mode
		w[7] = mpie_b;
		w[3] = mie_b;
		return w;
	endfunction

	// --------------------
	// Compare tasks

	task automatic check_data(input string name, input csr_pkg::csr_data_t exp,
		input csr_pkg::csr_data_t act);
		if (act !== exp) begin
			data_errors++;
			$display("FAILED [%s] %s: expected %08h, actual %08h", test_name, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			bit_errors++;
			$display("FAILED [%s] %s: expected %b, actual %b", test_name, name, exp, act);
		end
	endtask

	// --------------------
	// Stimulus tasks, each starts and ends on a falling edge

	task automatic access(input logic [11:0] a, input logic we, input logic re,
		input csr_pkg::csr_wtype_e wt, input csr_pkg::csr_data_t wd,
		output csr_pkg::csr_data_t rd, output logic ill);
		addr  = a;
		wen   = we;
		ren   = re;
		wtype = wt;
		wdata = wd;
		#10;
		rd  = rdata;   // Combinational read
		ill = illegal;
		@(negedge clk); // Write lands on the rising edge in between
		wen = 1'b0;
		ren = 1'b0;
	endtask

	task automatic csr_write(input logic [11:0] a, input csr_pkg::csr_wtype_e wt,
		input csr_pkg::csr_data_t wd);
		csr_pkg::csr_data_t rd;
		logic               ill;
		access(a, 1'b1, 1'b0, wt, wd, rd, ill);
	endtask

	task automatic csr_read(input logic [11:0] a, output csr_pkg::csr_data_t rd);
		logic ill;
		access(a, 1'b0, 1'b1, csr_pkg::CSR_WTYPE_W, 32'h0, rd, ill);
	endtask

	// Samples the handshake, then lets one edge pass
	task automatic check_trap(input string name, input logic exp_vld, input logic exp_irq,
		input csr_pkg::csr_data_t exp_addr);
		#10;
		check_bit({name, " vld"}, exp_vld, trap_enter_vld);
		if (exp_vld) begin
			check_bit({name, " is_irq"}, exp_irq, trap_is_irq);
			check_data({name, " trap_addr"}, exp_addr, trap_addr);
		end
		@(negedge clk);
	endtask

	// --------------------
	// Directed tests

	task automatic test_register_access();
		csr_pkg::csr_data_t  exp_scratch;
		csr_pkg::csr_data_t  exp_mie;
		csr_pkg::csr_data_t  wd;
		csr_pkg::csr_data_t  rd;
		csr_pkg::csr_wtype_e wt;
		test_name   = "register access";
		exp_scratch = '0;
		exp_mie     = '0;
		for (int i = 0; i < 3; i++) begin
			wt = csr_pkg::csr_wtype_e'(i); // Write, set, clear
			wd = lfsr_word();
			csr_write(csr_pkg::CSR_MSCRATCH, wt, wd);
			exp_scratch = apply_wtype(exp_scratch, wd, wt);
			csr_read(csr_pkg::CSR_MSCRATCH, rd);
			check_data("mscratch", exp_scratch, rd);
			wd = lfsr_word();
			csr_write(csr_pkg::CSR_MIE, wt, wd);
			exp_mie = apply_wtype(exp_mie, wd, wt) & 32'h0000_0888; // msie mtie meie
			csr_read(csr_pkg::CSR_MIE, rd);
			check_data("mie", exp_mie, rd);
		end
		wd = lfsr_word() | 32'h1;
		csr_write(csr_pkg::CSR_MEPC, csr_pkg::CSR_WTYPE_W, wd);
		csr_read(csr_pkg::CSR_MEPC, rd);
		check_data("mepc", wd & ~32'h1, rd);
	endtask

	task automatic test_illegal();
		csr_pkg::csr_data_t rd;
		logic               ill;
		test_name = "illegal detection";
		access(12'hb03, 1'b0, 1'b1, csr_pkg::CSR_WTYPE_W, 32'h0, rd, ill); // Old hpm slot
		check_bit("read unmapped", 1'b1, ill);
		access(12'h7c0, 1'b1, 1'b0, csr_pkg::CSR_WTYPE_W, 32'h0, rd, ill);
		check_bit("write unmapped", 1'b1, ill);
		access(csr_pkg::CSR_MEIP0, 1'b1, 1'b0, csr_pkg::CSR_WTYPE_S, 32'h1, rd, ill);
		check_bit("write meip0", 1'b1, ill);
		access(csr_pkg::CSR_MLEI, 1'b1, 1'b0, csr_pkg::CSR_WTYPE_W, 32'h3, rd, ill);
		check_bit("write mlei", 1'b1, ill);
		access(csr_pkg::CSR_MEIP0, 1'b0, 1'b1, csr_pkg::CSR_WTYPE_W, 32'h0, rd, ill);
		check_bit("read meip0", 1'b0, ill);
		access(csr_pkg::CSR_MIP, 1'b1, 1'b0, csr_pkg::CSR_WTYPE_W, 32'hffff_ffff, rd, ill);
		check_bit("write mip", 1'b0, ill);
		access(csr_pkg::CSR_MIP, 1'b0, 1'b1, csr_pkg::CSR_WTYPE_W, 32'h0, rd, ill);
		check_bit("read mip", 1'b0, ill);
		check_data("mip unchanged", 32'h0, rd);
		access(12'hb03, 1'b0, 1'b0, csr_pkg::CSR_WTYPE_W, 32'h0, rd, ill); // Idle cycle
		check_bit("idle", 1'b0, ill);
	endtask

	task automatic test_counters();
		csr_pkg::csr_data_t c0;
		csr_pkg::csr_data_t c1;
		csr_pkg::csr_data_t r0;
		csr_pkg::csr_data_t r1;
		csr_pkg::csr_data_t wd;
		test_name = "counters";
		csr_read(csr_pkg::CSR_MCYCLE, c0);
		repeat (IDLE_CYCLES) @(negedge clk);
		csr_read(csr_pkg::CSR_MCYCLE, c1);
		check_data("mcycle delta", IDLE_CYCLES + 1, c1 - c0); // First read adds one edge
		csr_read(csr_pkg::CSR_MINSTRET, r0);
		for (int i = 0; i < 5; i++) begin
			instr_ret = 1'b1;
			@(negedge clk);
			instr_ret = 1'b0;
			@(negedge clk);
		end
		csr_read(csr_pkg::CSR_MINSTRET, r1);
		check_data("minstret delta", 32'd5, r1 - r0);
		csr_write(csr_pkg::CSR_MCOUNTINHIBIT, csr_pkg::CSR_WTYPE_S, 32'h5); // cy and ir
		csr_read(csr_pkg::CSR_MCOUNTINHIBIT, wd);
		check_data("mcountinhibit", 32'h5, wd);
		csr_read(csr_pkg::CSR_MCYCLE, c0);
		csr_read(csr_pkg::CSR_MINSTRET, r0);
		instr_ret = 1'b1;
		repeat (4) @(negedge clk);
		instr_ret = 1'b0;
		csr_read(csr_pkg::CSR_MCYCLE, c1);
		csr_read(csr_pkg::CSR_MINSTRET, r1);
		check_data("mcycle inhibited", c0, c1);
		check_data("minstret inhibited", r0, r1);
		wd = lfsr_word();
		csr_write(csr_pkg::CSR_MCYCLEH, csr_pkg::CSR_WTYPE_W, wd);
		csr_read(csr_pkg::CSR_MCYCLEH, c1);
		check_data("mcycleh", wd, c1);
		csr_write(csr_pkg::CSR_MCOUNTINHIBIT, csr_pkg::CSR_WTYPE_C, 32'h5);
	endtask

	task automatic test_exception_mret();
		csr_pkg::csr_data_t old_mepc;
		csr_pkg::csr_data_t rd;
		test_name = "exception and mret";
		csr_write(csr_pkg::CSR_MTVEC, csr_pkg::CSR_WTYPE_W, 32'h0000_1000); // Direct mode
		csr_write(csr_pkg::CSR_MSTATUS, csr_pkg::CSR_WTYPE_S, 32'h8);
		csr_read(csr_pkg::CSR_MEPC, old_mepc);
		except         = csr_pkg::EXCEPT_ECALL;
		mepc_in        = 32'h0000_2005;
		trap_enter_rdy = 1'b0;
		check_trap("ecall held", 1'b1, 1'b0, 32'h0000_1000);
		csr_read(csr_pkg::CSR_MEPC, rd);
		check_data("mepc held", old_mepc, rd);
		csr_read(csr_pkg::CSR_MCAUSE, rd);
		check_data("mcause held", 32'h0, rd);
		csr_read(csr_pkg::CSR_MSTATUS, rd);
		check_data("mstatus held", mstatus_word(1'b1, 1'b0), rd);
		trap_enter_rdy = 1'b1; // Accept at the next edge
		@(negedge clk);
		trap_enter_rdy = 1'b0;
		except         = csr_pkg::EXCEPT_NONE;
		csr_read(csr_pkg::CSR_MEPC, rd);
		check_data("mepc entry", 32'h0000_2004, rd);
		csr_read(csr_pkg::CSR_MCAUSE, rd);
		check_data("mcause entry", 32'd11, rd);
		csr_read(csr_pkg::CSR_MSTATUS, rd);
		check_data("mstatus entry", mstatus_word(1'b0, 1'b1), rd);
		check_trap("after entry", 1'b0, 1'b0, 32'h0);
		except = csr_pkg::EXCEPT_MRET;
		check_trap("mret", 1'b1, 1'b0, 32'h0000_2004); // Return to mepc
		trap_enter_rdy = 1'b1;
		@(negedge clk);
		trap_enter_rdy = 1'b0;
		except         = csr_pkg::EXCEPT_NONE;
		csr_read(csr_pkg::CSR_MSTATUS, rd);
		check_data("mstatus mret", mstatus_word(1'b1, 1'b1), rd);
	endtask

	task automatic test_interrupts();
		csr_pkg::csr_data_t rd;
		test_name = "timer interrupt";
		csr_write(csr_pkg::CSR_MTVEC, csr_pkg::CSR_WTYPE_W, 32'h0000_1001); // Vectored
		csr_write(csr_pkg::CSR_MIE, csr_pkg::CSR_WTYPE_W, 32'h0000_0080);
		irq_timer = 1'b1;
		check_trap("not yet registered", 1'b0, 1'b0, 32'h0);
		check_trap("timer", 1'b1, 1'b1, 32'h0000_101c); // Base plus 4 x 7
		csr_read(csr_pkg::CSR_MIP, rd);
		check_data("mip timer", 32'h0000_0080, rd);
		delay_irq_entry = 1'b1;
		check_trap("delayed", 1'b0, 1'b0, 32'h0);
		delay_irq_entry = 1'b0;
		irq_timer       = 1'b0;
		@(negedge clk);
		check_trap("timer gone", 1'b0, 1'b0, 32'h0);
		test_name = "external interrupt";
		csr_read(csr_pkg::CSR_MEIE0, rd);
		check_data("meie0 reset", 32'h0000_ffff, rd);
		csr_write(csr_pkg::CSR_MIE, csr_pkg::CSR_WTYPE_W, 32'h0000_0800);
		irq = 16'h0220; // Lines 5 and 9
		@(negedge clk);
		csr_read(csr_pkg::CSR_MLEI, rd);
		check_data("mlei lower", 32'd5, rd);
		csr_read(csr_pkg::CSR_MEIP0, rd);
		check_data("meip0", 32'h0000_0220, rd);
		check_trap("summary", 1'b1, 1'b1, 32'h0000_102c); // Standard meip wins, code 11
		mepc_in        = 32'h0000_3000;
		trap_enter_rdy = 1'b1;
		@(negedge clk);
		trap_enter_rdy = 1'b0;
		csr_read(csr_pkg::CSR_MCAUSE, rd);
		check_data("mcause irq", 32'h8000_000b, rd);
		csr_read(csr_pkg::CSR_MEPC, rd);
		check_data("mepc irq", 32'h0000_3000, rd);
		check_trap("masked by mie", 1'b0, 1'b0, 32'h0);
		csr_write(csr_pkg::CSR_MEIE0, csr_pkg::CSR_WTYPE_C, 32'h0000_0020);
		csr_read(csr_pkg::CSR_MLEI, rd);
		check_data("mlei other", 32'd9, rd);
		irq = '0;
	endtask

	// --------------------
	// Main sequence

	initial begin
		rst_n           = 1'b0;
		addr            = '0;
		wdata           = '0;
		wen             = 1'b0;
		wtype           = csr_pkg::CSR_WTYPE_W;
		ren             = 1'b0;
		trap_enter_rdy  = 1'b0;
		mepc_in         = '0;
		except          = csr_pkg::EXCEPT_NONE;
		delay_irq_entry = 1'b0;
		irq             = '0;
		irq_software    = 1'b0;
		irq_timer       = 1'b0;
		instr_ret       = 1'b0;
		data_errors     = 0;
		bit_errors      = 0;
		lfsr_state      = 16'd56;
		repeat (10) @(negedge clk);
		rst_n     = 1'b1;
		test_name = "reset";
		#10;
		check_bit("illegal", 1'b0, illegal);
		check_trap("reset", 1'b0, 1'b0, 32'h0);
		test_register_access();
		test_illegal();
		test_counters();
		test_exception_mret();
		test_interrupts();
		repeat (2) @(negedge clk);
		$display("Errors: %0d data, %0d bit, %0d assertion", data_errors, bit_errors,
			u_csr_unit.u_chk.fail_count);
		if (data_errors == 0 && bit_errors == 0 && u_csr_unit.u_chk.fail_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/csr_unit_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_unit_chk (
	input  wire                 clk,
	input  wire                 rst_n,
	input  wire                 wen,
	input  wire                 ren,
	input  wire                 illegal,
	input  csr_pkg::csr_data_t  mepc,
	input  wire                 trap_take,
	input  csr_pkg::except_e    except,
	input  wire                 mstatus_mie
);

	int fail_count = 0; // Read by the testbench at the end of the run

	// --------------------
	// Access and trap rules

	a_illegal_needs_access: assert property (@(posedge clk) disable iff (!rst_n)
		illegal |-> (wen || ren))
	else begin
		fail_count++;
		$error("illegal raised without an access");
	end

	a_mepc_aligned: assert property (@(posedge clk) disable iff (!rst_n) !mepc[0])
	else begin
		fail_count++;
		$error("mepc bit 0 is set");
	end

	// Trap entry always closes the global enable
	a_entry_clears_mie: assert property (@(posedge clk) disable iff (!rst_n)
		(trap_take && except != csr_pkg::EXCEPT_MRET) |=> !mstatus_mie)
	else begin
		fail_count++;
		$error("mstatus.mie still set after trap entry");
	end

endmodule

bind csr_unit csr_unit_chk u_chk (
	.clk(clk), .rst_n(rst_n), .wen(wen), .ren(ren), .illegal(illegal), .mepc(mepc),
	.trap_take(trap_take), .except(except), .mstatus_mie(mstatus_mie)
);

`default_nettype wire

// ==== design/csr_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_unit #(
	parameter int                 NUM_IRQ    = 16,   // 1 to 16, bounded by the mcause code
	parameter csr_pkg::csr_data_t MTVEC_INIT = 32'h0
) (
	input  logic                 clk,
	input  logic                 rst_n,
	// CSR access, reads combinational
	input  logic [11:0]          addr,
	input  csr_pkg::csr_data_t   wdata,
	input  logic                 wen,
	input  csr_pkg::csr_wtype_e  wtype,
	input  logic                 ren,
	output csr_pkg::csr_data_t   rdata,
	output logic                 illegal,
	// Trap handshake
	output csr_pkg::csr_data_t   trap_addr,
	output logic                 trap_is_irq,
	output logic                 trap_enter_vld,
	input  logic                 trap_enter_rdy,
	input  csr_pkg::csr_data_t   mepc_in,
	// Core events and interrupt lines
	input  csr_pkg::except_e     except,
	input  logic                 delay_irq_entry,
	input  logic [NUM_IRQ-1:0]   irq,
	input  logic                 irq_software,
	input  logic                 irq_timer,
	input  logic                 instr_ret
);

	csr_write_if wr ();

	logic               mstatus_mie, mstatus_mpie;
	logic               trap_take;
	logic               cause_irq;
	logic [5:0]         cause_code;
	logic [4:0]         mlei;
	csr_pkg::csr_data_t mie, mtvec, mscratch, mepc, mcause, meie0, mip, meip0;
	csr_pkg::csr_data_t mcycle, mcycleh, minstret, minstreth, mcountinhibit;

	// --------------------
	// Write broadcast
	assign wr.wen   = wen;
	assign wr.wtype = wtype;
	assign wr.addr  = addr;
	assign wr.wdata = wdata;

	csr_trap_regs #(.NUM_IRQ(NUM_IRQ), .MTVEC_INIT(MTVEC_INIT)) u_trap_regs (
		.clk, .rst_n, .wr(wr.dst), .trap_take, .except, .mepc_in, .cause_irq, .cause_code,
		.mstatus_mie, .mstatus_mpie, .mie, .mtvec, .mscratch, .mepc, .mcause, .meie0
	);

	csr_counters u_counters (
		.clk, .rst_n, .wr(wr.dst), .instr_ret,
		.mcycle, .mcycleh, .minstret, .minstreth, .mcountinhibit
	);

	csr_trap_ctrl #(.NUM_IRQ(NUM_IRQ)) u_trap_ctrl (
		.clk, .rst_n, .irq, .irq_software, .irq_timer, .except, .delay_irq_entry,
		.trap_enter_rdy, .mstatus_mie, .mie, .meie0, .mtvec, .mepc,
		.mip, .meip0, .mlei, .trap_addr, .trap_is_irq, .trap_enter_vld, .trap_take,
		.cause_irq, .cause_code
	);

	// Read port sees plain wires, not the write bundle
	csr_read_mux u_read_mux (
		.addr, .wen, .ren, .mstatus_mie, .mstatus_mpie, .mie, .mtvec, .mscratch, .mepc,
		.mcause, .mip, .mcycle, .mcycleh, .minstret, .minstreth, .mcountinhibit,
		.meie0, .meip0, .mlei, .rdata, .illegal
	);

endmodule

`default_nettype wire

// ==== design/csr_read_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_read_mux (
	input  logic [11:0]         addr,
	input  logic                wen,
	input  logic                ren,
	input  logic                mstatus_mie,
	input  logic                mstatus_mpie,
	input  csr_pkg::csr_data_t  mie,
	input  csr_pkg::csr_data_t  mtvec,
	input  csr_pkg::csr_data_t  mscratch,
	input  csr_pkg::csr_data_t  mepc,
	input  csr_pkg::csr_data_t  mcause,
	input  csr_pkg::csr_data_t  mip,
	input  csr_pkg::csr_data_t  mcycle,
	input  csr_pkg::csr_data_t  mcycleh,
	input  csr_pkg::csr_data_t  minstret,
	input  csr_pkg::csr_data_t  minstreth,
	input  csr_pkg::csr_data_t  mcountinhibit,
	input  csr_pkg::csr_data_t  meie0,
	input  csr_pkg::csr_data_t  meip0,
	input  logic [4:0]          mlei,
	output csr_pkg::csr_data_t  rdata,
	output logic                illegal
);

	logic decode_match; // Address is mapped for this kind of access

	always_comb begin
		decode_match = 1'b1;
		rdata        = '0;
		case (addr)
			csr_pkg::CSR_MSTATUS: begin
				rdata[12:11] = 2'b11; // MPP, always M-mode
				rdata[csr_pkg::MSTATUS_MPIE_BIT] = mstatus_mpie;
				rdata[csr_pkg::MSTATUS_MIE_BIT]  = mstatus_mie;
			end
			csr_pkg::CSR_MIE:           rdata = mie;
			csr_pkg::CSR_MTVEC:         rdata = mtvec;   // Base plus mode bit
			csr_pkg::CSR_MSCRATCH:      rdata = mscratch;
			csr_pkg::CSR_MEPC:          rdata = mepc;
			csr_pkg::CSR_MCAUSE:        rdata = mcause;
			csr_pkg::CSR_MIP:           rdata = mip;     // Writes accepted, no effect
			csr_pkg::CSR_MCOUNTINHIBIT: rdata = mcountinhibit;
			csr_pkg::CSR_MCYCLE:        rdata = mcycle;
			csr_pkg::CSR_MCYCLEH:       rdata = mcycleh;
			csr_pkg::CSR_MINSTRET:      rdata = minstret;
			csr_pkg::CSR_MINSTRETH:     rdata = minstreth;
			csr_pkg::CSR_MEIE0:         rdata = meie0;
			csr_pkg::CSR_MEIP0: begin
				decode_match = !wen; // Read only
				rdata        = meip0;
			end
			csr_pkg::CSR_MLEI: begin
				decode_match = !wen; // Read only
				rdata        = {{(csr_pkg::XLEN - 5){1'b0}}, mlei};
			end
			default:
				decode_match = 1'b0; // Unmapped, including the old hpm slots
		endcase
	end

	// Only flag when something is actually accessing
	assign illegal = (wen || ren) && !decode_match;

endmodule

`default_nettype wire

// ==== design/csr_trap_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_trap_ctrl #(
	parameter int NUM_IRQ = 16
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [NUM_IRQ-1:0]  irq,            // Level sensitive external lines
	input  logic                irq_software,
	input  logic                irq_timer,
	input  csr_pkg::except_e    except,
	input  logic                delay_irq_entry,
	input  logic                trap_enter_rdy,
	input  logic                mstatus_mie,
	input  csr_pkg::csr_data_t  mie,
	input  csr_pkg::csr_data_t  meie0,
	input  csr_pkg::csr_data_t  mtvec,
	input  csr_pkg::csr_data_t  mepc,
	output csr_pkg::csr_data_t  mip,
	output csr_pkg::csr_data_t  meip0,
	output logic [4:0]          mlei,
	output csr_pkg::csr_data_t  trap_addr,
	output logic                trap_is_irq,
	output logic                trap_enter_vld,
	output logic                trap_take,
	output logic                cause_irq,
	output logic [5:0]          cause_code
);

	// Lowest set bit wins
	function automatic logic [4:0] lowest_index(input csr_pkg::csr_data_t req);
		logic [4:0] idx;
		idx = '0;
		for (int i = csr_pkg::XLEN - 1; i >= 0; i--) begin
			if (req[i])
				idx = 5'(i);
		end
		return idx;
	endfunction

	logic [NUM_IRQ-1:0] irq_r;
	logic               irq_software_r;
	logic               irq_timer_r;
	logic               ext_pending;   // Any enabled external line pending
	logic               std_active;
	logic               ext_active;
	logic [4:0]         std_num;
	logic               exc_req;
	logic [5:0]         irq_code;
	logic [5:0]         vector_sel;

	// --------------------
	// Input registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq_r          <= '0;
			irq_software_r <= 1'b0;
			irq_timer_r    <= 1'b0;
		end else begin
			irq_r          <= irq;
			irq_software_r <= irq_software;
			irq_timer_r    <= irq_timer;
		end
	end

	assign meip0       = {{(csr_pkg::XLEN - NUM_IRQ){1'b0}}, irq_r};
	assign ext_pending = |(meie0 & meip0);

	always_comb begin
		mip = '0;
		mip[csr_pkg::MIP_MSIP_BIT] = irq_software_r;
		mip[csr_pkg::MIP_MTIP_BIT] = irq_timer_r;
		mip[csr_pkg::MIP_MEIP_BIT] = ext_pending; // Summary always joins the standard irqs
	end

	// --------------------
	// Priority and vector

	assign std_active = |(mip & mie) && mstatus_mie;
	assign ext_active = ext_pending && mstatus_mie && mie[csr_pkg::MIP_MEIP_BIT];
	assign std_num    = lowest_index(mip & mie);
	assign mlei       = lowest_index(meie0 & meip0);
	assign exc_req    = except != csr_pkg::EXCEPT_NONE;

	assign irq_code = std_active ? {1'b0, std_num} :
		ext_active ? {1'b0, mlei} + csr_pkg::EXT_IRQ_CODE_BASE : 6'd0;
	assign vector_sel = (exc_req || !mtvec[0]) ? 6'd0 : irq_code; // Direct mode uses base

	assign trap_addr = except == csr_pkg::EXCEPT_MRET ? mepc :
		{mtvec[csr_pkg::XLEN-1:2], 2'b00} + {24'd0, vector_sel, 2'b00};
	assign trap_is_irq    = !exc_req;
	assign trap_enter_vld = exc_req || (!delay_irq_entry && (std_active || ext_active));
	assign trap_take      = trap_enter_vld && trap_enter_rdy;

	assign cause_irq  = !exc_req;
	assign cause_code = exc_req ? {2'b00, except} : irq_code;

endmodule

`default_nettype wire

// ==== design/csr_counters.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_counters (
	input  logic                clk,
	input  logic                rst_n,
	csr_write_if.dst            wr,
	input  logic                instr_ret,     // One instruction retired this cycle
	output csr_pkg::csr_data_t  mcycle,
	output csr_pkg::csr_data_t  mcycleh,
	output csr_pkg::csr_data_t  minstret,
	output csr_pkg::csr_data_t  minstreth,
	output csr_pkg::csr_data_t  mcountinhibit
);

	logic [63:0]        ctr [2]; // 0 is cycle, 1 is instret
	logic [1:0]         ctr_inc;
	logic               inhibit_cy;
	logic               inhibit_ir;
	csr_pkg::csr_data_t inhibit_upd;

	assign ctr_inc = {instr_ret && !inhibit_ir, !inhibit_cy};

	// Same update for both counters, only the addresses differ
	for (genvar i = 0; i < 2; i++) begin : g_ctr
		localparam logic [11:0] LO_ADDR = (i == 0) ? csr_pkg::CSR_MCYCLE  : csr_pkg::CSR_MINSTRET;
		localparam logic [11:0] HI_ADDR = (i == 0) ? csr_pkg::CSR_MCYCLEH : csr_pkg::CSR_MINSTRETH;

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				ctr[i] <= '0;
			end else if (wr.wen && wr.addr == LO_ADDR) begin // Write replaces the increment
				ctr[i][31:0] <= csr_pkg::csr_update(ctr[i][31:0], wr.wdata, wr.wtype);
			end else if (wr.wen && wr.addr == HI_ADDR) begin
				ctr[i][63:32] <= csr_pkg::csr_update(ctr[i][63:32], wr.wdata, wr.wtype);
			end else if (ctr_inc[i]) begin
				ctr[i] <= ctr[i] + 64'd1;
			end
		end
	end

	// --------------------
	// Inhibit bits, cy at 0 and ir at 2

	assign mcountinhibit = {29'd0, inhibit_ir, 1'b0, inhibit_cy};
	assign inhibit_upd   = csr_pkg::csr_update(mcountinhibit, wr.wdata, wr.wtype);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			inhibit_cy <= 1'b0; // Count from reset
			inhibit_ir <= 1'b0;
		end else if (wr.wen && wr.addr == csr_pkg::CSR_MCOUNTINHIBIT) begin
			inhibit_cy <= inhibit_upd[0];
			inhibit_ir <= inhibit_upd[2];
		end
	end

	assign mcycle    = ctr[0][31:0];
	assign mcycleh   = ctr[0][63:32];
	assign minstret  = ctr[1][31:0];
	assign minstreth = ctr[1][63:32];

endmodule

`default_nettype wire

// ==== design/csr_trap_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_trap_regs #(
	parameter int                 NUM_IRQ    = 16,
	parameter csr_pkg::csr_data_t MTVEC_INIT = 32'h0
) (
	input  logic                clk,
	input  logic                rst_n,
	csr_write_if.dst            wr,
	input  logic                trap_take,  // Trap entry or mret accepted this cycle
	input  csr_pkg::except_e    except,
	input  csr_pkg::csr_data_t  mepc_in,
	input  logic                cause_irq,
	input  logic [5:0]          cause_code,
	output logic                mstatus_mie,
	output logic                mstatus_mpie,
	output csr_pkg::csr_data_t  mie,
	output csr_pkg::csr_data_t  mtvec,
	output csr_pkg::csr_data_t  mscratch,
	output csr_pkg::csr_data_t  mepc,
	output csr_pkg::csr_data_t  mcause,
	output csr_pkg::csr_data_t  meie0
);

	localparam csr_pkg::csr_data_t MTVEC_WMASK = 32'hffff_fffd; // Bit 1 of mode reads 0
	localparam csr_pkg::csr_data_t MEIE0_WMASK = ~({csr_pkg::XLEN{1'b1}} << NUM_IRQ);

	csr_pkg::csr_data_t mstatus_cur; // mstatus as software sees the two bits
	csr_pkg::csr_data_t mstatus_upd;
	csr_pkg::csr_data_t mcause_upd;
	logic               mcause_irq;
	logic [5:0]         mcause_code;
	logic               is_mret;

	assign is_mret = except == csr_pkg::EXCEPT_MRET;

	always_comb begin
		mstatus_cur = '0;
		mstatus_cur[csr_pkg::MSTATUS_MIE_BIT]  = mstatus_mie;
		mstatus_cur[csr_pkg::MSTATUS_MPIE_BIT] = mstatus_mpie;
	end

	assign mstatus_upd = csr_pkg::csr_update(mstatus_cur, wr.wdata, wr.wtype);
	assign mcause_upd  = csr_pkg::csr_update(mcause, wr.wdata, wr.wtype);

	// --------------------
	// Interrupt enable stack

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mstatus_mie  <= 1'b0; // No interrupts until software enables them
			mstatus_mpie <= 1'b0;
		end else if (trap_take) begin // Trap beats a software write
			if (is_mret) begin
				mstatus_mie  <= mstatus_mpie;
				mstatus_mpie <= 1'b1;
			end else begin
				mstatus_mpie <= mstatus_mie;
				mstatus_mie  <= 1'b0;
			end
		end else if (wr.wen && wr.addr == csr_pkg::CSR_MSTATUS) begin
			mstatus_mie  <= mstatus_upd[csr_pkg::MSTATUS_MIE_BIT];
			mstatus_mpie <= mstatus_upd[csr_pkg::MSTATUS_MPIE_BIT];
		end
	end

	// --------------------
	// Plain software registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mie      <= '0;
			mtvec    <= MTVEC_INIT & MTVEC_WMASK;
			mscratch <= '0;
			meie0    <= MEIE0_WMASK; // All implemented lines enabled
		end else if (wr.wen) begin
			case (wr.addr)
				csr_pkg::CSR_MIE:
					mie <= csr_pkg::csr_update(mie, wr.wdata, wr.wtype) & csr_pkg::MIE_WMASK;
				csr_pkg::CSR_MTVEC:
					mtvec <= csr_pkg::csr_update(mtvec, wr.wdata, wr.wtype) & MTVEC_WMASK;
				csr_pkg::CSR_MSCRATCH:
					mscratch <= csr_pkg::csr_update(mscratch, wr.wdata, wr.wtype);
				csr_pkg::CSR_MEIE0:
					meie0 <= csr_pkg::csr_update(meie0, wr.wdata, wr.wtype) & MEIE0_WMASK;
				default: ;
			endcase
		end
	end

	// --------------------
	// Trap capture

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mepc        <= '0;
			mcause_irq  <= 1'b0;
			mcause_code <= '0;
		end else if (trap_take && !is_mret) begin
			mepc        <= {mepc_in[csr_pkg::XLEN-1:1], 1'b0}; // Halfword aligned at least
			mcause_irq  <= cause_irq;
			mcause_code <= cause_code;
		end else if (wr.wen && wr.addr == csr_pkg::CSR_MEPC) begin
			mepc <= csr_pkg::csr_update(mepc, wr.wdata, wr.wtype) & ~32'h1;
		end else if (wr.wen && wr.addr == csr_pkg::CSR_MCAUSE) begin
			mcause_irq  <= mcause_upd[31];
			mcause_code <= mcause_upd[5:0];
		end
	end

	assign mcause = {mcause_irq, 25'd0, mcause_code}; // Only irq flag and code kept

endmodule

`default_nettype wire

// ==== design/csr_write_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// One CSR write, broadcast to every block that holds registers
interface csr_write_if;

	logic                   wen;   // Write strobe, takes effect at next edge
	csr_pkg::csr_wtype_e    wtype; // Write, set or clear
	logic [11:0]            addr;  // May be unmapped, so not the enum type
	csr_pkg::csr_data_t     wdata;

	// Driven from the top level ports
	modport src (output wen, output wtype, output addr, output wdata);

	// Register holders sample the write at the clock edge
	modport dst (input wen, input wtype, input addr, input wdata);

endinterface

`default_nettype wire

// ==== design/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

	// --------------------
	// Widths and basic types

	localparam int XLEN = 32; // Fixed data width of the core

	typedef logic [XLEN-1:0] csr_data_t;

	// Machine-mode CSR addresses implemented by this block
	typedef enum logic [11:0] {
		CSR_MSTATUS       = 12'h300,
		CSR_MCOUNTINHIBIT = 12'h320, // Inhibit bits for mcycle and minstret
		CSR_MIE           = 12'h304,
		CSR_MTVEC         = 12'h305,
		CSR_MSCRATCH      = 12'h340,
		CSR_MEPC          = 12'h341,
		CSR_MCAUSE        = 12'h342,
		CSR_MIP           = 12'h344, // Read only, writes ignored
		CSR_MCYCLE        = 12'hb00,
		CSR_MINSTRET      = 12'hb02,
		CSR_MCYCLEH       = 12'hb80,
		CSR_MINSTRETH     = 12'hb82,
		CSR_MEIE0         = 12'hbe0, // Custom external irq enables
		CSR_MEIP0         = 12'hfe0, // Custom external irq pending, read only
		CSR_MLEI          = 12'hfe4  // Lowest enabled pending external irq
	} csr_addr_e;

	// Write flavours of the CSR instructions
	typedef enum logic [1:0] {
		CSR_WTYPE_W = 2'h0, // Plain write
		CSR_WTYPE_S = 2'h1, // Set bits
		CSR_WTYPE_C = 2'h2  // Clear bits
	} csr_wtype_e;

	// Exception causes from the core, mret rides along here too
	typedef enum logic [3:0] {
		EXCEPT_INSTR_MISALIGN = 4'h0,
		EXCEPT_ILLEGAL_INSTR  = 4'h2,
		EXCEPT_BREAKPOINT     = 4'h3,
		EXCEPT_LOAD_FAULT     = 4'h5,
		EXCEPT_STORE_FAULT    = 4'h7,
		EXCEPT_MRET           = 4'ha,
		EXCEPT_ECALL          = 4'hb,
		EXCEPT_NONE           = 4'hf  // No trap requested by the core
	} except_e;

	// --------------------
	// Bit positions and masks

	localparam logic [4:0] MSTATUS_MIE_BIT  = 5'd3;
	localparam logic [4:0] MSTATUS_MPIE_BIT = 5'd7;

	localparam logic [4:0] MIP_MSIP_BIT = 5'd3;  // Software
	localparam logic [4:0] MIP_MTIP_BIT = 5'd7;  // Timer
	localparam logic [4:0] MIP_MEIP_BIT = 5'd11; // External summary

	localparam csr_data_t MIE_WMASK = 32'h0000_0888; // msie, mtie, meie only

	localparam logic [5:0] EXT_IRQ_CODE_BASE = 6'd16; // mcause code of external irq 0

	// Write, set or clear of a whole word; callers apply their own write mask
	function automatic csr_data_t csr_update(
		input csr_data_t  prev,
		input csr_data_t  wdata,
		input csr_wtype_e wtype
	);
		csr_data_t result;
		case (wtype)
			CSR_WTYPE_S: result = prev | wdata;
			CSR_WTYPE_C: result = prev & ~wdata;
			default:     result = wdata;
		endcase
		return result;
	endfunction

endpackage

`default_nettype wire
